// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing
LINT_FLAGS = --lint-only -Wall
TOP        = fp_sgn_unit_tb
RTL_TOP    = fp_sgn_unit
FILELIST   = fp_sgn_unit.f
INC_DIR    = include
RTL_SRCS   = rtl/fp_sgn_pkg.sv rtl/fp_decomp_stage.sv rtl/fp_op_stage.sv \
             rtl/fp_class_stage.sv rtl/fp_sgn_unit.sv
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation ended without a verdict"; exit 1)
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+$(INC_DIR) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: fp_sgn_unit.f
+incdir+include
rtl/fp_sgn_pkg.sv
rtl/fp_decomp_stage.sv
rtl/fp_op_stage.sv
rtl/fp_class_stage.sv
rtl/fp_sgn_unit.sv
sim/fp_sgn_unit_tb.sv

// File: include/fp_sgn_params.svh
`ifndef FP_SGN_PARAMS_SVH
`define FP_SGN_PARAMS_SVH

// Double precision operand layout
`define FP_WID      64
`define FP_EXP_W    11
`define FP_SIG_W    52

// Special exponent codes
`define FP_EXP_MAX  11'h7ff     // Infinity and NaN
`define FP_EXP_BIAS 11'h3ff     // Exponent of 1.0

// Operation code
`define FP_FUNC_W   3

`endif

// File: rtl/fp_class_stage.sv
`include "fp_sgn_params.svh"

module fp_class_stage
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    s2_valid,
	input  fp_sgn_pkg::fp_func_t    s2_func,
	input  logic [`FP_WID-1:0]      s2_result,
	output logic                    out_valid,
	output logic [`FP_WID-1:0]      result,
	output logic                    flag_neg,
	output logic                    flag_pos,
	output logic                    flag_zero,
	output logic                    flag_inf,
	output logic                    flag_c,
	output logic                    ust
);
	import fp_sgn_pkg::*;

	logic                 r_sign;
	logic [`FP_EXP_W-1:0] r_exp;
	logic [`FP_SIG_W-1:0] r_sig;
	logic                 mag_zero;
	logic                 upd;

	assign r_sign   = s2_result[`FP_WID-1];
	assign r_exp    = s2_result[`FP_WID-2:`FP_SIG_W];
	assign r_sig    = s2_result[`FP_SIG_W-1:0];
	assign mag_zero = (s2_result[`FP_WID-2:0] == '0);

	// Only the sign operations touch the status flags
	always_comb
	begin
		case (s2_func)
		FN_SGNJ, FN_SGNJN, FN_SGNJX, FN_SIGN: upd = s2_valid;
		default:                              upd = 1'b0;
		endcase
	end

	// ==============================
	// Output registers
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			ust       <= 1'b0;
			flag_neg  <= 1'b0;
			flag_pos  <= 1'b0;
			flag_zero <= 1'b0;
			flag_inf  <= 1'b0;
			flag_c    <= 1'b0;
		end
		else
		begin
			out_valid <= s2_valid;
			ust       <= upd;
			flag_neg  <= upd && r_sign && !mag_zero;
			flag_pos  <= upd && !r_sign && !mag_zero;
			flag_zero <= upd && mag_zero;
			flag_inf  <= upd && (r_exp == `FP_EXP_MAX) && (r_sig == '0);
			flag_c    <= upd && (
				((r_exp == '0) && (r_sig != '0)) ||	// Denormal
				(r_sign && mag_zero) ||	// Negative zero
				((r_exp == `FP_EXP_MAX) && r_sig[`FP_SIG_W-1]));	// Quiet NaN
		end
	end

	always_ff @(posedge clk)
	begin
		if (s2_valid)
			result <= s2_result;
	end

endmodule

// File: rtl/fp_decomp_stage.sv
`include "fp_sgn_params.svh"

module fp_decomp_stage
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    in_valid,
	input  fp_sgn_pkg::fp_func_t    in_func,
	input  logic [`FP_WID-1:0]      a,
	input  logic [`FP_WID-1:0]      b,
	output logic                    s1_valid,
	output fp_sgn_pkg::fp_func_t    s1_func,
	output logic [`FP_WID-1:0]      s1_a,
	output logic [`FP_WID-1:0]      s1_b,
	output logic                    s1_a_zero,
	output logic                    s1_a_nan
);
	import fp_sgn_pkg::*;

	logic [`FP_EXP_W-1:0] a_exp;
	logic [`FP_SIG_W-1:0] a_sig;
	logic                 a_zero;
	logic                 a_nan;

	// ==============================
	// Field split of operand a
	// ==============================
	assign a_exp = a[`FP_WID-2:`FP_SIG_W];
	assign a_sig = a[`FP_SIG_W-1:0];

	assign a_zero = (a_exp == '0) && (a_sig == '0);	// Either sign
	assign a_nan  = (a_exp == `FP_EXP_MAX) && (a_sig != '0);	// Quiet or signalling

	always_ff @(posedge clk)
	begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	// Payload only loads with a new operation
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			s1_func   <= in_func;
			s1_a      <= a;
			s1_b      <= b;
			s1_a_zero <= a_zero;
			s1_a_nan  <= a_nan;
		end
	end

endmodule

// File: rtl/fp_op_stage.sv
`include "fp_sgn_params.svh"

module fp_op_stage
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    s1_valid,
	input  fp_sgn_pkg::fp_func_t    s1_func,
	input  logic [`FP_WID-1:0]      s1_a,
	input  logic [`FP_WID-1:0]      s1_b,
	input  logic                    s1_a_zero,
	input  logic                    s1_a_nan,
	output logic                    s2_valid,
	output fp_sgn_pkg::fp_func_t    s2_func,
	output logic [`FP_WID-1:0]      s2_result
);
	import fp_sgn_pkg::*;

	logic                 a_sign;
	logic                 b_sign;
	logic [`FP_WID-2:0]   b_mag;
	logic [`FP_WID-1:0]   sign_res;
	logic [`FP_WID-1:0]   op_res;

	assign a_sign = s1_a[`FP_WID-1];
	assign b_sign = s1_b[`FP_WID-1];
	assign b_mag  = s1_b[`FP_WID-2:0];

	// FSIGN passes zero and NaN through, anything else becomes +-1.0
	assign sign_res = (s1_a_zero || s1_a_nan) ? s1_a :
		{a_sign, `FP_EXP_BIAS, {`FP_SIG_W{1'b0}}};

	// ==============================
	// Operation select
	// ==============================
	always_comb
	begin
		case (s1_func)
		FN_SGNJ:  op_res = {a_sign, b_mag};
		FN_SGNJN: op_res = {~a_sign, b_mag};
		FN_SGNJX: op_res = {a_sign ^ b_sign, b_mag};
		FN_SIGN:  op_res = sign_res;
		FN_SIG:   op_res = {{(`FP_WID-`FP_SIG_W){1'b0}}, s1_a[`FP_SIG_W-1:0]};
		default:  op_res = '0;	// Unused codes
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			s2_valid <= 1'b0;
		else
			s2_valid <= s1_valid;
	end

	always_ff @(posedge clk)
	begin
		if (s1_valid)
		begin
			s2_func   <= s1_func;
			s2_result <= op_res;
		end
	end

endmodule

// File: rtl/fp_sgn_pkg.sv
`include "fp_sgn_params.svh"

package fp_sgn_pkg;

	// ==============================
	// Operation codes
	// ==============================
	// Codes 5 to 7 are unused and give a zero result
	typedef enum logic [`FP_FUNC_W-1:0]
	{
		FN_SGNJ  = 3'd0,	// Sign of a, magnitude of b
		FN_SGNJN = 3'd1,	// Inverted sign of a
		FN_SGNJX = 3'd2,	// Sign a xor sign b
		FN_SIGN  = 3'd3,	// +-1.0 from a
		FN_SIG   = 3'd4	// Significand of a
	} fp_func_t;

endpackage

// File: rtl/fp_sgn_unit.sv
`include "fp_sgn_params.svh"

module fp_sgn_unit
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    in_valid,
	input  fp_sgn_pkg::fp_func_t    in_func,
	input  logic [`FP_WID-1:0]      a,
	input  logic [`FP_WID-1:0]      b,
	output logic                    out_valid,
	output logic [`FP_WID-1:0]      result,
	output logic                    flag_neg,
	output logic                    flag_pos,
	output logic                    flag_zero,
	output logic                    flag_inf,
	output logic                    flag_c,
	output logic                    ust
);
	import fp_sgn_pkg::*;

	// Stage 1 outputs
	logic                 s1_valid;
	fp_func_t             s1_func;
	logic [`FP_WID-1:0]   s1_a;
	logic [`FP_WID-1:0]   s1_b;
	logic                 s1_a_zero;
	logic                 s1_a_nan;

	// Stage 2 outputs
	logic                 s2_valid;
	fp_func_t             s2_func;
	logic [`FP_WID-1:0]   s2_result;

	// ==============================
	// Three stage chain
	// ==============================
	fp_decomp_stage u_decomp (.clk(clk), .reset(reset), .in_valid(in_valid),
		.in_func(in_func), .a(a), .b(b), .s1_valid(s1_valid), .s1_func(s1_func),
		.s1_a(s1_a), .s1_b(s1_b), .s1_a_zero(s1_a_zero), .s1_a_nan(s1_a_nan));

	fp_op_stage u_op (.clk(clk), .reset(reset), .s1_valid(s1_valid),
		.s1_func(s1_func), .s1_a(s1_a), .s1_b(s1_b), .s1_a_zero(s1_a_zero),
		.s1_a_nan(s1_a_nan), .s2_valid(s2_valid), .s2_func(s2_func),
		.s2_result(s2_result));

	fp_class_stage u_class (.clk(clk), .reset(reset), .s2_valid(s2_valid),
		.s2_func(s2_func), .s2_result(s2_result), .out_valid(out_valid),
		.result(result), .flag_neg(flag_neg), .flag_pos(flag_pos),
		.flag_zero(flag_zero), .flag_inf(flag_inf), .flag_c(flag_c), .ust(ust));

endmodule

// File: sim/fp_sgn_unit_tb.sv
`include "fp_sgn_params.svh"

module fp_sgn_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import fp_sgn_pkg::*;

	localparam int NUM_OPS     = 1500;
	localparam int CYCLE_LIMIT = 4 * NUM_OPS + 100;

	logic                 clk;
	logic                 reset;
	logic                 in_valid;
	fp_func_t             in_func;
	logic [`FP_WID-1:0]   a;
	logic [`FP_WID-1:0]   b;
	logic                 out_valid;
	logic [`FP_WID-1:0]   result;
	logic                 flag_neg;
	logic                 flag_pos;
	logic                 flag_zero;
	logic                 flag_inf;
	logic                 flag_c;
	logic                 ust;

	integer               seed;
	int                   cycle_count;
	int                   issued;
	int                   func_count [8];
	logic                 checking;

	// Expected outputs in issue order
	logic [`FP_WID-1:0]   exp_res_q [$];
	logic [5:0]           exp_stat_q [$];	// ust neg pos zero inf c
	int                   due_q [$];

	fp_sgn_unit dut0 (.clk(clk), .reset(reset), .in_valid(in_valid), .in_func(in_func),
		.a(a), .b(b), .out_valid(out_valid), .result(result), .flag_neg(flag_neg),
		.flag_pos(flag_pos), .flag_zero(flag_zero), .flag_inf(flag_inf),
		.flag_c(flag_c), .ust(ust));

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==============================
	// Reference model
	// ==============================
	function automatic logic [63:0] model_result(input logic [2:0] fn,
		input logic [63:0] x, input logic [63:0] y);
		logic x_special;
		x_special = (x[62:0] == 63'h0) || ((x[62:52] == 11'h7ff) && (x[51:0] != 52'h0));
		case (fn)
		3'd0: return {x[63], y[62:0]};
		3'd1: return {~x[63], y[62:0]};
		3'd2: return {x[63] ^ y[63], y[62:0]};
		3'd3: return x_special ? x : {x[63], 11'h3ff, 52'h0};	// +-1.0
		3'd4: return {12'h0, x[51:0]};
		default: return 64'h0;
		endcase
	endfunction

	function automatic logic [5:0] model_status(input logic [2:0] fn, input logic [63:0] r);
		logic zero;
		logic neg;
		logic pos;
		logic inf;
		logic c;
		if (fn > 3'd3)
			return 6'b0;	// No status update
		zero = (r[62:0] == 63'h0);
		neg  = r[63] && !zero;
		pos  = !r[63] && !zero;
		inf  = (r[62:52] == 11'h7ff) && (r[51:0] == 52'h0);
		c    = ((r[62:52] == 11'h0) && (r[51:0] != 52'h0)) || (r[63] && zero) ||
			((r[62:52] == 11'h7ff) && r[51]);
		return {1'b1, neg, pos, zero, inf, c};
	endfunction

	// ==============================
	// Checking
	// ==============================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_val(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected)
			abort_run($sformatf("ERR %s got %h expected %h", name, got, expected));
	endtask

	// One operand in four from the special table
	task automatic pick_operand(output logic [63:0] v);
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		if (hi[1:0] != 2'b00)
			v = {hi, lo};
		else
		begin
			case (lo[2:0])
			3'd0: v = 64'h0000_0000_0000_0000;	// +0
			3'd1: v = 64'h8000_0000_0000_0000;	// -0
			3'd2: v = 64'h7ff0_0000_0000_0000;	// +inf
			3'd3: v = 64'hfff0_0000_0000_0000;	// -inf
			3'd4: v = 64'h7ff8_0000_0000_0000;	// Quiet NaN
			3'd5: v = 64'h7ff0_0000_0000_0001;	// Signalling NaN
			3'd6: v = {hi[31], 11'h0, 20'h0, lo[31:3], 3'b101};	// Denormal
			default: v = {lo[31], 63'h3ff0_0000_0000_0000};	// +-1.0
			endcase
		end
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
			abort_run($sformatf("Timeout after %0d cycles", cycle_count));
	end

	// Outputs are stable away from the rising edge
	always @(negedge clk)
	begin
		logic [5:0] st;
		if (checking)
		begin
			if (out_valid)
			begin
				if (exp_res_q.size() == 0)
					abort_run("out_valid came with no operation outstanding");
				st = exp_stat_q.pop_front();
				check_val("latency", 64'(cycle_count), 64'(due_q.pop_front()));
				check_val("result", result, exp_res_q.pop_front());
				check_val("ust", 64'(ust), 64'(st[5]));
				check_val("flag_neg", 64'(flag_neg), 64'(st[4]));
				check_val("flag_pos", 64'(flag_pos), 64'(st[3]));
				check_val("flag_zero", 64'(flag_zero), 64'(st[2]));
				check_val("flag_inf", 64'(flag_inf), 64'(st[1]));
				check_val("flag_c", 64'(flag_c), 64'(st[0]));
			end
			else
			begin
				// Idle cycles keep status low
				check_val("ust", 64'(ust), 64'h0);
				check_val("flags", 64'({flag_neg, flag_pos, flag_zero, flag_inf, flag_c}),
					64'h0);
			end
		end
	end

	// ==============================
	// Stimulus
	// ==============================
	initial
	begin
		logic [31:0]  r;
		logic [2:0]   fn;
		logic [63:0]  op_a;
		logic [63:0]  op_b;
		logic [63:0]  res;
		seed        = 42056;
		cycle_count = 0;
		issued      = 0;
		checking    = 1'b0;
		reset       = 1'b1;
		in_valid    = 1'b0;
		in_func     = FN_SGNJ;
		a           = '0;
		b           = '0;
		for (int i = 0; i < 8; i++)
			func_count[i] = 0;

		repeat (3) @(posedge clk);
		reset    <= 1'b0;
		checking = 1'b1;

		while (issued < NUM_OPS)
		begin
			@(posedge clk);
			r = $random(seed);
			pick_operand(op_a);
			pick_operand(op_b);
			a <= op_a;
			b <= op_b;
			if (r[1:0] != 2'b00)
			begin
				fn = r[4:2];
				res = model_result(fn, op_a, op_b);
				in_valid <= 1'b1;
				in_func  <= fp_func_t'(fn);
				exp_res_q.push_back(res);
				exp_stat_q.push_back(model_status(fn, res));
				due_q.push_back(cycle_count + 4);	// Out three edges after issue
				func_count[fn]++;
				issued++;
			end
			else
				in_valid <= 1'b0;	// Gap with junk operands
		end
		@(posedge clk);
		in_valid <= 1'b0;

		repeat (8) @(posedge clk);	// Last result plus idle cycles with no stray out_valid

		for (int i = 0; i < 8; i++)
			$display("Function code %0d issued %0d times", i, func_count[i]);

		if (exp_res_q.size() == 0)
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
		else
			abort_run($sformatf("%0d operations never came out", exp_res_q.size()));
	end

endmodule
